//--- hdl/l2_pkg.sv
package l2_pkg;

   // geometry
   localparam int ADDR_WIDTH   = 32;
   localparam int LINE_BYTES   = 16;
   localparam int LINE_WIDTH   = LINE_BYTES * 8;
   localparam int OFFSET_WIDTH = 4;
   localparam int INDEX_WIDTH  = 4;
   localparam int NUM_SETS     = 2 ** INDEX_WIDTH;
   localparam int NUM_WAYS     = 4;
   localparam int LOG_WAYS     = 2;
   localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
   localparam int ID_WIDTH     = 8;

   typedef logic [LINE_WIDTH-1:0]   line_t;
   typedef logic [LINE_BYTES-1:0]   strb_t;
   typedef logic [TAG_WIDTH-1:0]    tag_t;
   typedef logic [INDEX_WIDTH-1:0]  index_t;
   typedef logic [LOG_WAYS-1:0]     way_t;
   typedef logic [ID_WIDTH-1:0]     id_t;

   typedef struct packed {
      tag_t                    tag;
      index_t                  index;
      logic [OFFSET_WIDTH-1:0] offset;
   } addr_t;

   // 0 is the next victim, NUM_WAYS-1 the most recent
   typedef logic [LOG_WAYS-1:0] rank_t;

   typedef enum logic {INVALID, VALID} line_state_t;

   typedef struct packed {
      line_state_t state;
      tag_t        tag;
      logic        dirty;
      rank_t       rank;
   } tag_way_t;

   typedef tag_way_t [NUM_WAYS-1:0] tag_entry_t;

   // data array address as set then way
   typedef struct packed {
      index_t index;
      way_t   way;
   } data_addr_t;

   typedef struct packed {
      logic  is_write;
      id_t   id;
      addr_t addr;
      line_t wdata;
      strb_t wstrb;
   } core_req_t;

   typedef struct packed {
      logic  is_write;
      id_t   id;
      line_t rdata;
   } core_resp_t;

   typedef struct packed {
      logic  is_write;
      addr_t addr;
      line_t wdata;
   } mem_req_t;

endpackage

//--- hdl/l2_tag_array.sv
`timescale 1ns/1ns

module l2_tag_array (
   input  logic               clk,
   input  logic               rstn,

   input  logic               i_ren,
   input  l2_pkg::index_t     i_rindex,

   input  logic               i_wen,
   input  l2_pkg::index_t     i_windex,
   input  l2_pkg::tag_entry_t i_wentry,

   output l2_pkg::tag_entry_t o_rentry
);
   import l2_pkg::*;

   tag_entry_t mem [NUM_SETS];
   tag_entry_t rd_q;
   tag_entry_t byp_q;
   logic       collide_q;

   always_ff @(posedge clk) begin
      if (i_wen) begin
         mem[i_windex] <= i_wentry;
      end
      if (i_ren) begin
         rd_q  <= mem[i_rindex];
         byp_q <= i_wentry;
      end
   end

   // remember a same-cycle write to the index being read
   always_ff @(posedge clk) begin
      if (!rstn) begin
         collide_q <= 1'b0;
      end else if (i_ren) begin
         collide_q <= i_wen && (i_windex == i_rindex);
      end
   end

   // write-first view
   assign o_rentry = collide_q ? byp_q : rd_q;

endmodule

//--- hdl/l2_data_array.sv
`timescale 1ns/1ns

module l2_data_array (
   input  logic               clk,
   input  logic               i_en,
   input  l2_pkg::data_addr_t i_addr,
   input  l2_pkg::line_t      i_wdata,
   input  l2_pkg::strb_t      i_wstrb,
   output l2_pkg::line_t      o_rdata
);
   import l2_pkg::*;

   line_t mem [NUM_SETS*NUM_WAYS];

   // a written byte also goes straight to the output
   always_ff @(posedge clk) begin
      if (i_en) begin
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_wstrb[b]) begin
               mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
               o_rdata[b*8 +: 8]     <= i_wdata[b*8 +: 8];
            end else begin
               o_rdata[b*8 +: 8]     <= mem[i_addr][b*8 +: 8];
            end
         end
      end
   end

endmodule

//--- hdl/l2_way_select.sv
`timescale 1ns/1ns

module l2_way_select (
   input  l2_pkg::tag_entry_t i_entry,
   input  l2_pkg::tag_t       i_tag,
   output logic               o_hit,
   output l2_pkg::way_t       o_way
);
   import l2_pkg::*;

   typedef struct packed {
      rank_t rank;
      way_t  way;
      logic  hit;
   } node_t;

   // heap layout with the root at 0 and leaves from NUM_WAYS-1
   node_t node [2*NUM_WAYS-1];

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_leaf
      assign node[NUM_WAYS-1+w].rank = i_entry[w].rank;
      assign node[NUM_WAYS-1+w].way  = way_t'(w);
      assign node[NUM_WAYS-1+w].hit  = (i_entry[w].state == VALID) &&
                                       (i_entry[w].tag == i_tag);
   end

   // a hit beats any rank, else the lower rank survives
   for (genvar n = 0; n < NUM_WAYS-1; n++) begin : g_node
      always_comb begin
         if (node[2*n+1].hit) begin
            node[n] = node[2*n+1];
         end else if (node[2*n+2].hit) begin
            node[n] = node[2*n+2];
         end else if (node[2*n+1].rank < node[2*n+2].rank) begin
            node[n] = node[2*n+1];
         end else begin
            node[n] = node[2*n+2];
         end
      end
   end

   assign o_hit = node[0].hit;
   assign o_way = node[0].way;

endmodule

//--- hdl/l2_controller.sv
`timescale 1ns/1ns

module l2_controller (
   input  logic               clk,
   input  logic               rstn,

   input  logic               i_req_valid,
   input  l2_pkg::core_req_t  i_req,
   output logic               o_req_ready,

   output logic               o_resp_valid,
   output l2_pkg::core_resp_t o_resp,
   input  logic               i_resp_ready,

   output logic               o_mem_valid,
   output l2_pkg::mem_req_t   o_mem_req,
   input  logic               i_mem_ready,
   input  logic               i_mem_rvalid,
   input  l2_pkg::line_t      i_mem_rdata,

   output logic               o_tag_ren,
   output l2_pkg::index_t     o_tag_rindex,
   output logic               o_tag_wen,
   output l2_pkg::index_t     o_tag_windex,
   output l2_pkg::tag_entry_t o_tag_wentry,
   input  l2_pkg::tag_entry_t i_tag_entry,

   output l2_pkg::tag_t       o_lookup_tag,
   input  logic               i_hit,
   input  l2_pkg::way_t       i_way,

   output logic               o_data_en,
   output l2_pkg::data_addr_t o_data_addr,
   output l2_pkg::line_t      o_data_wdata,
   output l2_pkg::strb_t      o_data_wstrb,
   input  l2_pkg::line_t      i_data_rdata
);
   import l2_pkg::*;

   typedef enum logic [3:0] {
      S_INIT,
      S_IDLE,
      S_LOOKUP,
      S_HIT_ACCESS,
      S_VICT_RD,
      S_VICT_WR,
      S_REFILL_REQ,
      S_REFILL_WAIT,
      S_FILL,
      S_RESP
   } state_t;

   state_t     state;
   index_t     init_idx;
   core_req_t  req_q;
   line_t      fill_q;
   core_resp_t resp_q;
   logic       resp_valid;
   line_t      merged;
   logic       victim_dirty;
   addr_t      victim_addr;
   addr_t      refill_addr;

   // accessed way becomes most recent, ranks above it move down
   function automatic tag_entry_t promote(input tag_entry_t e, input way_t w);
      tag_entry_t r;
      r = e;
      for (int i = 0; i < NUM_WAYS; i++) begin
         if (i == int'(w)) begin
            r[i].rank = rank_t'(NUM_WAYS-1);
         end else if (e[i].rank > e[w].rank) begin
            r[i].rank = e[i].rank - 1'b1;
         end
      end
      return r;
   endfunction

   assign o_req_ready  = (state == S_IDLE);
   assign o_resp_valid = resp_valid;
   assign o_resp       = resp_q;

   // tag read goes out with the incoming request so the entry is ready in lookup
   assign o_tag_ren    = o_req_ready && i_req_valid;
   assign o_tag_rindex = i_req.addr.index;
   assign o_tag_windex = (state == S_INIT) ? init_idx : req_q.addr.index;
   assign o_lookup_tag = req_q.addr.tag;

   assign victim_dirty = (i_tag_entry[i_way].state == VALID) && i_tag_entry[i_way].dirty;

   always_comb begin
      victim_addr.tag    = i_tag_entry[i_way].tag;
      victim_addr.index  = req_q.addr.index;
      victim_addr.offset = '0;
      refill_addr        = req_q.addr;
      refill_addr.offset = '0;
   end

   // victim data sits on the array output until the next access
   assign o_mem_valid        = (state == S_VICT_WR) || (state == S_REFILL_REQ);
   assign o_mem_req.is_write = (state == S_VICT_WR);
   assign o_mem_req.addr     = (state == S_VICT_WR) ? victim_addr : refill_addr;
   assign o_mem_req.wdata    = i_data_rdata;

   // write bytes over the returned line
   always_comb begin
      for (int b = 0; b < LINE_BYTES; b++) begin
         if (req_q.is_write && req_q.wstrb[b]) begin
            merged[b*8 +: 8] = req_q.wdata[b*8 +: 8];
         end else begin
            merged[b*8 +: 8] = i_mem_rdata[b*8 +: 8];
         end
      end
   end

   always_comb begin
      o_tag_wen         = 1'b0;
      o_tag_wentry      = i_tag_entry;
      o_data_en         = 1'b0;
      o_data_addr.index = req_q.addr.index;
      o_data_addr.way   = i_way;
      o_data_wdata      = req_q.wdata;
      o_data_wstrb      = '0;
      case (state)
         S_INIT: begin
            o_tag_wen = 1'b1;
            for (int w = 0; w < NUM_WAYS; w++) begin
               o_tag_wentry[w].state = INVALID;
               o_tag_wentry[w].tag   = '0;
               o_tag_wentry[w].dirty = 1'b0;
               o_tag_wentry[w].rank  = rank_t'(w);
            end
         end
         S_HIT_ACCESS: begin
            o_data_en    = 1'b1;
            o_data_wstrb = req_q.is_write ? req_q.wstrb : '0;
            o_tag_wen    = 1'b1;
            o_tag_wentry = promote(i_tag_entry, i_way);
            if (req_q.is_write) begin
               o_tag_wentry[i_way].dirty = 1'b1;
            end
         end
         S_VICT_RD: begin
            o_data_en = 1'b1;
         end
         S_FILL: begin
            o_data_en    = 1'b1;
            o_data_wdata = fill_q;
            o_data_wstrb = '1;
            o_tag_wen    = 1'b1;
            o_tag_wentry = promote(i_tag_entry, i_way);
            o_tag_wentry[i_way].state = VALID;
            o_tag_wentry[i_way].tag   = req_q.addr.tag;
            o_tag_wentry[i_way].dirty = req_q.is_write;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state      <= S_INIT;
         init_idx   <= '0;
         resp_valid <= 1'b0;
      end else begin
         case (state)
            S_INIT: begin
               init_idx <= init_idx + 1'b1;
               if (init_idx == '1) begin
                  state <= S_IDLE;
               end
            end
            S_IDLE: begin
               if (i_req_valid) begin
                  state <= S_LOOKUP;
               end
            end
            S_LOOKUP: begin
               if (i_hit) begin
                  state <= S_HIT_ACCESS;
               end else if (victim_dirty) begin
                  state <= S_VICT_RD;
               end else begin
                  state <= S_REFILL_REQ;
               end
            end
            S_HIT_ACCESS:  state <= S_RESP;
            S_VICT_RD:     state <= S_VICT_WR;
            S_VICT_WR: begin
               if (i_mem_ready) begin
                  state <= S_REFILL_REQ;
               end
            end
            S_REFILL_REQ: begin
               if (i_mem_ready) begin
                  state <= S_REFILL_WAIT;
               end
            end
            S_REFILL_WAIT: begin
               if (i_mem_rvalid) begin
                  state <= S_FILL;
               end
            end
            S_FILL:        state <= S_RESP;
            S_RESP: begin
               // first cycle loads the response register
               if (!resp_valid) begin
                  resp_valid <= 1'b1;
               end else if (i_resp_ready) begin
                  resp_valid <= 1'b0;
                  state      <= S_IDLE;
               end
            end
            default:       state <= S_INIT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (o_req_ready && i_req_valid) begin
         req_q <= i_req;
      end
      if (state == S_REFILL_WAIT && i_mem_rvalid) begin
         fill_q <= merged;
      end
      if (state == S_RESP && !resp_valid) begin
         resp_q.is_write <= req_q.is_write;
         resp_q.id       <= req_q.id;
         resp_q.rdata    <= req_q.is_write ? '0 : i_data_rdata;
      end
   end

endmodule

//--- hdl/l2_cache.sv
`timescale 1ns/1ns

module l2_cache (
   input  logic               clk,
   input  logic               rstn,

   input  logic               i_req_valid,
   input  l2_pkg::core_req_t  i_req,
   output logic               o_req_ready,

   output logic               o_resp_valid,
   output l2_pkg::core_resp_t o_resp,
   input  logic               i_resp_ready,

   output logic               o_mem_valid,
   output l2_pkg::mem_req_t   o_mem_req,
   input  logic               i_mem_ready,
   input  logic               i_mem_rvalid,
   input  l2_pkg::line_t      i_mem_rdata
);
   import l2_pkg::*;

   logic       tag_ren;
   index_t     tag_rindex;
   logic       tag_wen;
   index_t     tag_windex;
   tag_entry_t tag_wentry;
   tag_entry_t tag_rentry;

   tag_t       lookup_tag;
   logic       hit;
   way_t       way;

   logic       data_en;
   data_addr_t data_addr;
   line_t      data_wdata;
   strb_t      data_wstrb;
   line_t      data_rdata;

   l2_controller CTRL (
      .clk          (clk),
      .rstn         (rstn),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .o_req_ready  (o_req_ready),
      .o_resp_valid (o_resp_valid),
      .o_resp       (o_resp),
      .i_resp_ready (i_resp_ready),
      .o_mem_valid  (o_mem_valid),
      .o_mem_req    (o_mem_req),
      .i_mem_ready  (i_mem_ready),
      .i_mem_rvalid (i_mem_rvalid),
      .i_mem_rdata  (i_mem_rdata),
      .o_tag_ren    (tag_ren),
      .o_tag_rindex (tag_rindex),
      .o_tag_wen    (tag_wen),
      .o_tag_windex (tag_windex),
      .o_tag_wentry (tag_wentry),
      .i_tag_entry  (tag_rentry),
      .o_lookup_tag (lookup_tag),
      .i_hit        (hit),
      .i_way        (way),
      .o_data_en    (data_en),
      .o_data_addr  (data_addr),
      .o_data_wdata (data_wdata),
      .o_data_wstrb (data_wstrb),
      .i_data_rdata (data_rdata)
   );

   l2_tag_array TAG_ARRAY (
      .clk      (clk),
      .rstn     (rstn),
      .i_ren    (tag_ren),
      .i_rindex (tag_rindex),
      .i_wen    (tag_wen),
      .i_windex (tag_windex),
      .i_wentry (tag_wentry),
      .o_rentry (tag_rentry)
   );

   l2_way_select WAY_SELECT (
      .i_entry (tag_rentry),
      .i_tag   (lookup_tag),
      .o_hit   (hit),
      .o_way   (way)
   );

   l2_data_array DATA_ARRAY (
      .clk     (clk),
      .i_en    (data_en),
      .i_addr  (data_addr),
      .i_wdata (data_wdata),
      .i_wstrb (data_wstrb),
      .o_rdata (data_rdata)
   );

endmodule

//--- tb/l2_controller_sva.sv
`timescale 1ns/1ns

module l2_controller_sva (
   input logic               clk,
   input logic               rstn,
   input logic               o_req_ready,
   input logic               o_resp_valid,
   input l2_pkg::core_resp_t o_resp,
   input logic               i_resp_ready,
   input logic               o_mem_valid,
   input l2_pkg::mem_req_t   o_mem_req,
   input logic               i_mem_ready
);

   int fail_count = 0;

   // response held until the requester takes it
   resp_stable: assert property (
      @(posedge clk) disable iff (!rstn)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp)
   ) else begin
      $error("response changed while stalled");
      fail_count++;
   end

   mem_req_stable: assert property (
      @(posedge clk) disable iff (!rstn)
      o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_req)
   ) else begin
      $error("memory request changed while stalled");
      fail_count++;
   end

   // one request in flight
   no_accept_during_resp: assert property (
      @(posedge clk) disable iff (!rstn)
      o_resp_valid |-> !o_req_ready
   ) else begin
      $error("request ready while a response is pending");
      fail_count++;
   end

endmodule

bind l2_controller l2_controller_sva sva (
   .clk          (clk),
   .rstn         (rstn),
   .o_req_ready  (o_req_ready),
   .o_resp_valid (o_resp_valid),
   .o_resp       (o_resp),
   .i_resp_ready (i_resp_ready),
   .o_mem_valid  (o_mem_valid),
   .o_mem_req    (o_mem_req),
   .i_mem_ready  (i_mem_ready)
);

//--- tb/tb_l2_cache.sv
`timescale 1ns/1ns

module tb_l2_cache;
   import l2_pkg::*;

   localparam int WAIT_LIMIT   = 400;
   localparam int RESET_CYCLES = 10;

   logic        clk;
   logic        rstn;
   logic        i_req_valid;
   core_req_t   i_req;
   logic        o_req_ready;
   logic        o_resp_valid;
   core_resp_t  o_resp;
   logic        i_resp_ready;
   logic        o_mem_valid;
   mem_req_t    o_mem_req;
   logic        i_mem_ready;
   logic        i_mem_rvalid;
   line_t       i_mem_rdata;

   // sparse backing memory with a fill pattern for unwritten bytes
   logic [7:0]  mem_bytes [logic [31:0]];
   int          mem_reads;
   int          mem_writes;
   logic        write_after_read;
   logic        rd_pending;
   int          rd_delay;
   logic [31:0] rd_addr;

   int          cyc = 0;
   int          tests_run;
   int          tests_failed;
   int          errors;
   logic        timed_out;

   l2_cache DUT (
      .clk          (clk),
      .rstn         (rstn),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .o_req_ready  (o_req_ready),
      .o_resp_valid (o_resp_valid),
      .o_resp       (o_resp),
      .i_resp_ready (i_resp_ready),
      .o_mem_valid  (o_mem_valid),
      .o_mem_req    (o_mem_req),
      .i_mem_ready  (i_mem_ready),
      .i_mem_rvalid (i_mem_rvalid),
      .i_mem_rdata  (i_mem_rdata)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic logic [7:0] fill_byte(input logic [31:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
   endfunction

   function automatic line_t load_line(input logic [31:0] a);
      line_t       l;
      logic [31:0] ba;
      for (int b = 0; b < LINE_BYTES; b++) begin
         ba = a + 32'(b);
         if (mem_bytes.exists(ba)) begin
            l[b*8 +: 8] = mem_bytes[ba];
         end else begin
            l[b*8 +: 8] = fill_byte(ba);
         end
      end
      return l;
   endfunction

   task automatic store_line(input logic [31:0] a, input line_t l);
      for (int b = 0; b < LINE_BYTES; b++) begin
         mem_bytes[a + 32'(b)] = l[b*8 +: 8];
      end
   endtask

   // memory model and random back-pressure
   always @(posedge clk) begin
      if (rstn && o_mem_valid && i_mem_ready) begin
         if (o_mem_req.is_write) begin
            store_line(o_mem_req.addr, o_mem_req.wdata);
            mem_writes++;
            if (mem_reads > 0) begin
               write_after_read = 1'b1;
            end
         end else begin
            mem_reads++;
            rd_pending = 1'b1;
            rd_addr    = o_mem_req.addr;
            rd_delay   = int'($urandom_range(3, 0));
         end
      end
      #1;
      i_mem_rvalid = 1'b0;
      if (rd_pending) begin
         if (rd_delay == 0) begin
            i_mem_rvalid = 1'b1;
            i_mem_rdata  = load_line(rd_addr);
            rd_pending   = 1'b0;
         end else begin
            rd_delay--;
         end
      end
      i_mem_ready  = ($urandom_range(3, 0) != 0);
      i_resp_ready = ($urandom_range(3, 0) != 0);
   end

   task automatic report_mismatch(input string name, input string what,
                                  input logic [127:0] expected, input logic [127:0] actual);
      $display("[ERROR] %s: %s expected %0h actual %0h", name, what, expected, actual);
      errors++;
   endtask

   task automatic finish_test(input string name, input int err_before);
      if (errors == err_before) begin
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s", name);
         tests_failed++;
      end
   endtask

   task automatic run_test(input string name, input logic [7:0] op, input logic [31:0] addr,
                           input line_t wdata, input strb_t strb, input line_t exp_data,
                           input logic [7:0] kind);
      int         wait_cnt;
      int         acc_cyc;
      int         valid_cyc;
      int         err_before;
      logic       seen;
      logic       done;
      id_t        id;
      core_resp_t resp;

      err_before = errors;
      id         = id_t'(tests_run);
      tests_run++;
      @(posedge clk);
      #1;
      mem_reads        = 0;
      mem_writes       = 0;
      write_after_read = 1'b0;
      i_req_valid      = 1'b1;
      i_req.is_write   = (op == "W");
      i_req.id         = id;
      i_req.addr       = addr;
      i_req.wdata      = wdata;
      i_req.wstrb      = strb;

      wait_cnt = 0;
      done     = 1'b0;
      while (!done && wait_cnt < WAIT_LIMIT) begin
         @(posedge clk);
         wait_cnt++;
         if (o_req_ready) begin
            done    = 1'b1;
            acc_cyc = cyc;
         end
      end
      #1;
      i_req_valid = 1'b0;
      if (!done) begin
         $display("[ERROR] %s: request not accepted within %0d cycles", name, WAIT_LIMIT);
         errors++;
         timed_out = 1'b1;
         finish_test(name, err_before);
         return;
      end

      wait_cnt = 0;
      seen     = 1'b0;
      done     = 1'b0;
      while (!done && wait_cnt < WAIT_LIMIT) begin
         @(posedge clk);
         wait_cnt++;
         if (o_resp_valid && !seen) begin
            seen      = 1'b1;
            valid_cyc = cyc;
         end
         if (o_resp_valid && i_resp_ready) begin
            done = 1'b1;
            resp = o_resp;
         end
      end
      if (!done) begin
         $display("[ERROR] %s: no response within %0d cycles", name, WAIT_LIMIT);
         errors++;
         timed_out = 1'b1;
         finish_test(name, err_before);
         return;
      end

      if (resp.id != id) begin
         report_mismatch(name, "id", id, resp.id);
      end
      if (resp.is_write != (op == "W")) begin
         report_mismatch(name, "is_write", (op == "W"), resp.is_write);
      end
      if (op == "R" && resp.rdata != exp_data) begin
         report_mismatch(name, "rdata", exp_data, resp.rdata);
      end
      case (kind)
         "H": begin
            if (mem_reads != 0 || mem_writes != 0) begin
               $display("[ERROR] %s: hit caused memory traffic", name);
               errors++;
            end
            // valid is seen one edge after the edge that raised it
            if (valid_cyc - acc_cyc - 1 != 3) begin
               report_mismatch(name, "hit latency", 3, valid_cyc - acc_cyc - 1);
            end
         end
         "M", "D": begin
            if (mem_reads != 1) begin
               report_mismatch(name, "memory reads", 1, mem_reads);
            end
            if (mem_writes != ((kind == "D") ? 1 : 0)) begin
               report_mismatch(name, "memory writes", (kind == "D") ? 1 : 0, mem_writes);
            end
            if (write_after_read) begin
               $display("[ERROR] %s: victim write-back came after the refill read", name);
               errors++;
            end
         end
         default: begin
            $display("[ERROR] %s: unknown result code in test file", name);
            errors++;
         end
      endcase
      finish_test(name, err_before);
   endtask

   initial begin
      int          fd;
      int          n;
      int          wait_cnt;
      string       line;
      string       name;
      logic [7:0]  op;
      logic [7:0]  kind;
      logic [31:0] addr;
      line_t       wdata;
      strb_t       strb;
      line_t       exp_data;

      void'($urandom(32'h52331e21));
      clk              = 1'b0;
      rstn             = 1'b0;
      i_req_valid      = 1'b0;
      i_req            = '0;
      i_resp_ready     = 1'b0;
      i_mem_ready      = 1'b0;
      i_mem_rvalid     = 1'b0;
      i_mem_rdata      = '0;
      mem_reads        = 0;
      mem_writes       = 0;
      write_after_read = 1'b0;
      rd_pending       = 1'b0;
      rd_delay         = 0;
      rd_addr          = '0;
      tests_run        = 0;
      tests_failed     = 0;
      errors           = 0;
      timed_out        = 1'b0;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstn = 1'b1;

      // tag init walk runs before the first request can be taken
      wait_cnt = 0;
      do begin
         @(posedge clk);
         wait_cnt++;
      end while (!o_req_ready && wait_cnt < WAIT_LIMIT);
      if (!o_req_ready) begin
         $display("[ERROR] cache never became ready after reset");
         errors++;
         timed_out = 1'b1;
      end else if (o_resp_valid || o_mem_valid) begin
         $display("[ERROR] response or memory valid high while idle after reset");
         errors++;
      end

      fd = $fopen("tb/l2_tests.dat", "r");
      if (fd == 0) begin
         $display("[ERROR] could not open tb/l2_tests.dat");
         errors++;
      end else begin
         while (!timed_out && $fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") begin
               continue;
            end
            n = $sscanf(line, "%s %c %h %h %h %h %c",
                        name, op, addr, wdata, strb, exp_data, kind);
            if (n <= 0) begin
               continue;
            end
            if (n != 7) begin
               $display("[ERROR] malformed test line: %s", line);
               errors++;
               continue;
            end
            run_test(name, op, addr, wdata, strb, exp_data, kind);
         end
         $fclose(fd);
      end
      if (tests_run == 0) begin
         $display("[ERROR] no tests were read from the test file");
         errors++;
      end
      if (DUT.CTRL.sva.fail_count != 0) begin
         $display("[ERROR] %0d handshake assertion failures", DUT.CTRL.sva.fail_count);
         errors += DUT.CTRL.sva.fail_count;
      end

      $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0 && !timed_out) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- tb/l2_tests.dat
# name op(R/W) addr wdata strb expected_rdata result(H hit, M miss, D miss with write-back)
# memory fill byte at address a is a[7:0]^a[15:8]^a[23:16]^a[31:24]
cold_rd      R 00001010 0 0000 0f0e0d0c0b0a09080706050403020100 M
wr_hit       W 00001010 ffeeddccbbaa99887766554433221100 00f0 0 H
rd_after_wr  R 0000101c 0 0000 0f0e0d0c0b0a09087766554403020100 H
wr_miss      W 00002020 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 8001 0 M
rd_wr_miss   R 00002020 0 0000 a50e0d0c0b0a090807060504030201a5 H
ev_wr_t0     W 00003030 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 000f 0 M
ev_rd_t1     R 01003030 0 0000 0e0f0c0d0a0b08090607040502030001 M
ev_rd_t2     R 02003030 0 0000 0d0c0f0e09080b0a0504070601000302 M
ev_rd_t3     R 03003030 0 0000 0c0d0e0f08090a0b0405060700010203 M
ev_rd_t4     R 04003030 0 0000 0b0a09080f0e0d0c0302010007060504 D
ev_rd_t0     R 00003030 0 0000 0f0e0d0c0b0a0908070605045a5a5a5a M
lru_rd_t0    R 00004040 0 0000 0f0e0d0c0b0a09080706050403020100 M
lru_rd_t1    R 01004040 0 0000 0e0f0c0d0a0b08090607040502030001 M
lru_rd_t2    R 02004040 0 0000 0d0c0f0e09080b0a0504070601000302 M
lru_rd_t3    R 03004040 0 0000 0c0d0e0f08090a0b0405060700010203 M
lru_touch_t0 R 00004040 0 0000 0f0e0d0c0b0a09080706050403020100 H
lru_rd_t4    R 04004040 0 0000 0b0a09080f0e0d0c0302010007060504 M
lru_keep_t0  R 00004040 0 0000 0f0e0d0c0b0a09080706050403020100 H
lru_miss_t1  R 01004040 0 0000 0e0f0c0d0a0b08090607040502030001 M
wr_hit_hi    W 01004040 0123456789abcdef0123456789abcdef ff00 0 H
rd_hit_hi    R 01004040 0 0000 0123456789abcdef0607040502030001 H
cold_rd_s5   R 0000505c 0 0000 0f0e0d0c0b0a09080706050403020100 M
rd_hit_s5    R 00005050 0 0000 0f0e0d0c0b0a09080706050403020100 H
rd_t3_again  R 03004040 0 0000 0c0d0e0f08090a0b0405060700010203 H
rd_s1_again  R 00001010 0 0000 0f0e0d0c0b0a09087766554403020100 H
rd_s2_again  R 0000202c 0 0000 a50e0d0c0b0a090807060504030201a5 H

//--- tb.f
hdl/l2_pkg.sv
hdl/l2_tag_array.sv
hdl/l2_data_array.sv
hdl/l2_way_select.sv
hdl/l2_controller.sv
hdl/l2_cache.sv
tb/l2_controller_sva.sv
tb/tb_l2_cache.sv

//--- Makefile
TOP = tb_l2_cache
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

obj_dir/V$(TOP): tb.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir $(LOG)
